// ==== rv_frontend_patterns.txt ====
# W word_index data | R target_pc fetch_count
# E pc rd rs1 rs2 funct3 imm (hex, in decode order)
W 00 002081B3
W 01 FFF30293
W 02 00812383
W 03 FE952E23
W 04 7FF280E7
W 05 40E68633
W 06 12345037
W 3F 7FF012A3
R 00000000 6
E 00000000 03 01 02 0 00000000
E 00000004 05 06 00 0 FFFFFFFF
E 00000008 07 02 00 2 00000008
E 0000000C 00 0A 09 2 FFFFFFFC
E 00000010 01 05 00 0 000007FF
E 00000014 0C 0D 0E 0 00000000
R 000000FC 3
E 000000FC 00 00 1F 1 000007E5
E 00000100 03 01 02 0 00000000
E 00000104 05 06 00 0 FFFFFFFF
R FFFFFFFC 3
E FFFFFFFC 00 00 1F 1 000007E5
E 00000000 03 01 02 0 00000000
E 00000004 05 06 00 0 FFFFFFFF

// ==== rv_frontend.f ====
rv_fetch_pkg.sv
rv_isa_pkg.sv
incrementer.sv
fetch_unit.sv
instr_mem.sv
decode_stage.sv
rv_frontend_top.sv
rv_frontend_checker.sv
tb_rv_frontend.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f rv_frontend.f --top-module tb_rv_frontend -o sim_rv_frontend
./obj_dir/sim_rv_frontend > sim.log 2>&1 || true
cat sim.log
if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
grep -q "TESTS PASSED" sim.log

// ==== tb_rv_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_frontend
    import rv_fetch_pkg::*;
    import rv_isa_pkg::*;
;

    logic clk = 1'b0;
    logic rst_n, fetch_en, redirect, imem_wr_en;
    logic [XLEN-1:0] redirect_pc, imem_wr_data;
    logic [IMEM_AW_DEFAULT-1:0] imem_wr_addr;
    wire logic dec_valid, dec_is_rtype;
    wire logic [XLEN-1:0] dec_pc, dec_imm;
    wire logic [6:0] dec_opcode;
    wire logic [4:0] dec_rd, dec_rs1, dec_rs2;
    wire logic [2:0] dec_funct3;

    int seed = 56;
    int cycles = 0;
    int cycle_limit = 0;
    int n_records = 0;
    int setup_errors = 0;
    int total_errors;
    int fd;
    string line;
    logic [7:0] kind[$];
    logic [31:0] arg_a[$];
    logic [31:0] arg_b[$];
    logic [31:0] a, b, c, d, e, f;
    logic [6:0] op;
    logic [31:0] mem_model [2**IMEM_AW_DEFAULT]; // Words as loaded by the W records.
    bit started = 0;

    always #2 clk = ~clk;

    rv_frontend_top #(.IMEM_AW(IMEM_AW_DEFAULT)) UUT
    (
        .clk(clk), .rst_n(rst_n), .fetch_en(fetch_en), .redirect(redirect),
        .redirect_pc(redirect_pc), .imem_wr_en(imem_wr_en), .imem_wr_addr(imem_wr_addr),
        .imem_wr_data(imem_wr_data), .dec_valid(dec_valid), .dec_pc(dec_pc),
        .dec_opcode(dec_opcode), .dec_rd(dec_rd), .dec_rs1(dec_rs1), .dec_rs2(dec_rs2),
        .dec_funct3(dec_funct3), .dec_imm(dec_imm), .dec_is_rtype(dec_is_rtype)
    );

    rv_frontend_checker u_chk
    (
        .clk(clk), .dec_valid(dec_valid), .dec_pc(dec_pc), .dec_opcode(dec_opcode),
        .dec_rd(dec_rd), .dec_rs1(dec_rs1), .dec_rs2(dec_rs2), .dec_funct3(dec_funct3),
        .dec_imm(dec_imm), .dec_is_rtype(dec_is_rtype)
    );

    // Drives every control input for one clock cycle.
    task automatic drive_cycle(input logic en, input logic redir, input logic [31:0] target,
                               input logic wr, input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        fetch_en     <= en;
        redirect     <= redir;
        redirect_pc  <= target;
        imem_wr_en   <= wr;
        imem_wr_addr <= addr[IMEM_AW_DEFAULT-1:0];
        imem_wr_data <= data;
    endtask

    always @(posedge clk)
    begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit)
        begin
            $display("Timeout after %0d cycles waiting for decodes.", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial
    begin
        {rst_n, fetch_en, redirect, imem_wr_en} = 4'b0000;
        {redirect_pc, imem_wr_data, imem_wr_addr} = '0;
        fd = $fopen("rv_frontend_patterns.txt", "r");
        if (fd == 0)
            $display("Could not open the pattern file.");
        while (fd != 0 && $fgets(line, fd) != 0)
        begin
            if (line.len() < 2 || line[0] == "#")
                continue;
            n_records++;
            if (line[0] == "E")
            begin
                void'($sscanf(line, "E %h %h %h %h %h %h", a, b, c, d, e, f));
                // Higher PCs alias onto the RAM through the low word-index bits.
                op = mem_model[a[IMEM_AW_DEFAULT+1:2]][6:0];
                u_chk.push_expect(a, b[4:0], c[4:0], d[4:0], e[2:0], f, op,
                                  op == OPC_OP);
            end
            else
            begin
                void'($sscanf(line, "%c %h %h", c, a, b));
                if (line[0] == "W")
                    mem_model[a[IMEM_AW_DEFAULT-1:0]] = b;
                kind.push_back(line[0]);
                arg_a.push_back(a);
                arg_b.push_back(b);
            end
        end
        if (u_chk.pushed == 0)
        begin
            $display("No expected decode records were loaded from the pattern file.");
            setup_errors++;
        end
        cycle_limit = 4 * n_records + 100;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        foreach (kind[i])
        begin
            if (kind[i] == "W")
                drive_cycle(0, 0, 0, 1, arg_a[i], arg_b[i]);
            else
            begin
                // The request just before the redirect must be killed.
                if (started)
                    drive_cycle(1, 0, 0, 0, 0, 0);
                drive_cycle(1, 1, arg_a[i], 0, 0, 0);
                started = 1;
                for (int n = 0; n < arg_b[i]; n++)
                begin
                    if (($random(seed) & 3) == 0)
                        drive_cycle(0, 0, 0, 0, 0, 0);
                    drive_cycle(1, 0, 0, 0, 0, 0);
                end
            end
        end
        drive_cycle(0, 0, 0, 0, 0, 0);
        while (u_chk.pulses < u_chk.pushed)
            @(posedge clk);
        repeat (4) @(posedge clk); // Catch any stray decode.
        u_chk.final_check();
        total_errors = u_chk.errors + setup_errors;
        $display("Decodes %0d of %0d, errors %0d", u_chk.pulses, u_chk.pushed, total_errors);
        if (total_errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rv_frontend_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_frontend_checker
    import rv_fetch_pkg::*;
(
    input wire logic            clk,
    input wire logic            dec_valid,
    input wire logic [XLEN-1:0] dec_pc,
    input wire logic [6:0]      dec_opcode,
    input wire logic [4:0]      dec_rd,
    input wire logic [4:0]      dec_rs1,
    input wire logic [4:0]      dec_rs2,
    input wire logic [2:0]      dec_funct3,
    input wire logic [XLEN-1:0] dec_imm,
    input wire logic            dec_is_rtype
);

    // Each expected record packs the opcode, the R-type flag, pc, rd, rs1, rs2, funct3 and imm.
    logic [89:0] exp_q[$];
    int          errors = 0;
    int          pulses = 0;
    int          pushed = 0;

    task automatic push_expect(input logic [31:0] pc, input logic [4:0] rd,
                               input logic [4:0] rs1, input logic [4:0] rs2,
                               input logic [2:0] funct3, input logic [31:0] imm,
                               input logic [6:0] opcode, input logic rtype);
        exp_q.push_back({opcode, rtype, pc, rd, rs1, rs2, funct3, imm});
        pushed++;
    endtask

    task automatic compare_field(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] got_val);
        if (exp_val !== got_val)
        begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp_val, got_val);
            errors++;
        end
    endtask

    // Outputs are registered, so their values at the edge are settled.
    always @(posedge clk)
    begin
        logic [89:0] rec;
        if (dec_valid === 1'b1)
        begin
            pulses++;
            if (exp_q.size() == 0)
            begin
                $display("Decode at %0t with pc %h arrived but no record was expected.",
                         $time, dec_pc);
                errors++;
            end
            else
            begin
                rec = exp_q.pop_front();
                compare_field("dec_pc", rec[81:50], dec_pc);
                compare_field("dec_rd", {27'd0, rec[49:45]}, {27'd0, dec_rd});
                compare_field("dec_rs1", {27'd0, rec[44:40]}, {27'd0, dec_rs1});
                compare_field("dec_rs2", {27'd0, rec[39:35]}, {27'd0, dec_rs2});
                compare_field("dec_funct3", {29'd0, rec[34:32]}, {29'd0, dec_funct3});
                compare_field("dec_imm", rec[31:0], dec_imm);
                compare_field("dec_opcode", {25'd0, rec[89:83]}, {25'd0, dec_opcode});
                compare_field("dec_is_rtype", {31'd0, rec[82]}, {31'd0, dec_is_rtype});
            end
        end
    end

    task automatic final_check();
        if (exp_q.size() != 0)
        begin
            $display("%0d expected decode records were never seen.", exp_q.size());
            errors++;
        end
        if (pulses != pushed)
        begin
            $display("Saw %0d decode pulses but the pattern file has %0d.", pulses, pushed);
            errors++;
        end
    endtask

endmodule

`default_nettype wire

// ==== rv_frontend_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_frontend_top
    import rv_fetch_pkg::*;
#(
    parameter int IMEM_AW = IMEM_AW_DEFAULT
)
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               fetch_en,
    input  logic               redirect,
    input  logic [XLEN-1:0]    redirect_pc,
    input  logic               imem_wr_en,
    input  logic [IMEM_AW-1:0] imem_wr_addr,
    input  logic [XLEN-1:0]    imem_wr_data,
    output logic               dec_valid,
    output logic [XLEN-1:0]    dec_pc,
    output logic [6:0]         dec_opcode,
    output logic [4:0]         dec_rd,
    output logic [4:0]         dec_rs1,
    output logic [4:0]         dec_rs2,
    output logic [2:0]         dec_funct3,
    output logic [XLEN-1:0]    dec_imm,
    output logic               dec_is_rtype
);

    logic            imem_rd_en;
    logic [XLEN-3:0] imem_rd_addr;
    logic [XLEN-1:0] imem_rd_data;
    logic [XLEN-1:0] fetch_pc;
    logic            fetch_valid;

    fetch_unit u_fetch
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_en     (fetch_en),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .imem_rd_en   (imem_rd_en),
        .imem_rd_addr (imem_rd_addr),
        .fetch_pc     (fetch_pc),
        .fetch_valid  (fetch_valid)
    );

    // Only the low word-index bits reach the RAM, so higher PCs alias.
    instr_mem #(.IMEM_AW(IMEM_AW)) u_imem
    (
        .clk     (clk),
        .rd_en   (imem_rd_en),
        .rd_addr (imem_rd_addr[IMEM_AW-1:0]),
        .wr_en   (imem_wr_en),
        .wr_addr (imem_wr_addr),
        .wr_data (imem_wr_data),
        .rd_data (imem_rd_data)
    );

    decode_stage u_decode
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (redirect),
        .fetch_valid  (fetch_valid),
        .fetch_pc     (fetch_pc),
        .instr        (imem_rd_data),
        .dec_valid    (dec_valid),
        .dec_pc       (dec_pc),
        .dec_opcode   (dec_opcode),
        .dec_rd       (dec_rd),
        .dec_rs1      (dec_rs1),
        .dec_rs2      (dec_rs2),
        .dec_funct3   (dec_funct3),
        .dec_imm      (dec_imm),
        .dec_is_rtype (dec_is_rtype)
    );

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import rv_fetch_pkg::*;
    import rv_isa_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            flush,
    input  logic            fetch_valid,
    input  logic [XLEN-1:0] fetch_pc,
    input  logic [XLEN-1:0] instr,
    output logic            dec_valid,
    output logic [XLEN-1:0] dec_pc,
    output logic [6:0]      dec_opcode,
    output logic [4:0]      dec_rd,
    output logic [4:0]      dec_rs1,
    output logic [4:0]      dec_rs2,
    output logic [2:0]      dec_funct3,
    output logic [XLEN-1:0] dec_imm,
    output logic            dec_is_rtype
);

    logic        valid_q;
    logic [XLEN-1:0] pc_q;
    instr_word_u word_q;

    // ##################
    // Pipeline register
    // ##################

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= fetch_valid & ~flush; // A redirect kills the arriving word.
        end
    end

    always_ff @(posedge clk)
    begin
        if (fetch_valid)
        begin
            word_q <= instr;
            pc_q   <= fetch_pc;
        end
    end

    // ##################
    // Field decode
    // ##################

    assign dec_valid    = valid_q;
    assign dec_pc       = pc_q;
    assign dec_opcode   = word_q.r_view.opcode;
    assign dec_is_rtype = (word_q.r_view.opcode == OPC_OP);

    always_comb
    begin
        // Fields sit in the same place in every view.
        dec_rd     = word_q.r_view.rd;
        dec_rs1    = word_q.r_view.rs1;
        dec_rs2    = 5'd0;
        dec_funct3 = word_q.r_view.funct3;
        dec_imm    = '0;
        case (word_q.r_view.opcode)
            OPC_OP:
            begin
                dec_rs2 = word_q.r_view.rs2;
            end
            OPC_OP_IMM, OPC_LOAD, OPC_JALR:
            begin
                dec_imm = {{(XLEN-12){word_q.i_view.imm12[11]}}, word_q.i_view.imm12};
            end
            OPC_STORE:
            begin
                dec_rd  = 5'd0; // Stores write no register.
                dec_rs2 = word_q.s_view.rs2;
                dec_imm = {{(XLEN-12){word_q.s_view.imm_hi[6]}},
                           word_q.s_view.imm_hi, word_q.s_view.imm_lo};
            end
            default:
            begin
                dec_imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== instr_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_mem
    import rv_fetch_pkg::*;
#(
    parameter int IMEM_AW = IMEM_AW_DEFAULT
)
(
    input  logic               clk,
    input  logic               rd_en,
    input  logic [IMEM_AW-1:0] rd_addr,
    input  logic               wr_en,
    input  logic [IMEM_AW-1:0] wr_addr,
    input  logic [XLEN-1:0]    wr_data,
    output logic [XLEN-1:0]    rd_data
);

    localparam int DEPTH = 2 ** IMEM_AW;

    logic [XLEN-1:0] mem [DEPTH];

    // Load port, used only while fetch is idle.
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read data is valid one cycle after the request and holds otherwise.
    always_ff @(posedge clk)
    begin
        if (rd_en)
        begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
    import rv_fetch_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            fetch_en,
    input  logic            redirect,
    input  logic [XLEN-1:0] redirect_pc,
    output logic            imem_rd_en,
    output logic [XLEN-3:0] imem_rd_addr,
    output logic [XLEN-1:0] fetch_pc,
    output logic            fetch_valid
);

    logic [XLEN-1:0] pc_q;
    logic [XLEN-3:0] pc_word_next; // Word index plus one.
    logic [XLEN-1:0] next_pc;

    // ##################
    // Next PC
    // ##################

    incrementer
    #(
        .LEN(XLEN - 2)
    )
    u_pc_inc
    (
        .value  (pc_q[XLEN-1:2]),
        .result (pc_word_next)
    );

    assign next_pc = {pc_word_next, 2'b00};

    // ##################
    // Memory request
    // ##################

    // A redirect in the same cycle makes the request useless, so none is sent.
    assign imem_rd_en   = fetch_en & ~redirect;
    assign imem_rd_addr = pc_q[XLEN-1:2];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            pc_q        <= RESET_PC;
            fetch_valid <= 1'b0;
        end
        else
        begin
            fetch_valid <= imem_rd_en; // Lines up with the memory read data.
            if (redirect)
            begin
                pc_q <= {redirect_pc[XLEN-1:2], 2'b00};
            end
            else if (fetch_en)
            begin
                pc_q <= next_pc;
            end
        end
    end

    // The PC of the request travels along with the read.
    always_ff @(posedge clk)
    begin
        if (imem_rd_en)
        begin
            fetch_pc <= pc_q;
        end
    end

endmodule

`default_nettype wire

// ==== incrementer.sv ====
`timescale 1ns/1ps
`default_nettype none

module incrementer
#(
    parameter int LEN = 32
)
(
    input  logic [LEN-1:0] value,
    output logic [LEN-1:0] result
);

    localparam int COUNT = LEN / 4;        // Full 4-bit groups.
    localparam int REM   = LEN - COUNT * 4; // Bits left for the ripple tail.

    // carry[g] says that every bit below group g is one.
    logic [COUNT:0] carry;

    assign carry[0] = 1'b1; // The lowest group always increments.

    // ##################
    // 4-bit groups
    // ##################

    for (genvar g = 0; g < COUNT; g++)
    begin : g_group
        logic [3:0] grp;
        logic [3:0] grp_inc;
        logic       all_ones;

        assign grp = value[g*4 +: 4];

        // Increment unit built from plain gates, no adder.
        assign grp_inc[0] = ~grp[0];
        assign grp_inc[1] = grp[1] ^ grp[0];
        assign grp_inc[2] = grp[2] ^ (grp[1] & grp[0]);
        assign grp_inc[3] = grp[3] ^ (grp[2] & grp[1] & grp[0]);
        assign all_ones   = &grp;

        // Select between the plain and the incremented copy.
        assign result[g*4 +: 4] = carry[g] ? grp_inc : grp;
        assign carry[g+1]       = carry[g] & all_ones;
    end

    // ##################
    // Ripple tail
    // ##################

    if (REM > 0)
    begin : g_tail
        assign result[LEN-1:COUNT*4] = value[LEN-1:COUNT*4] + REM'(carry[COUNT]);
    end

endmodule

`default_nettype wire

// ==== rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    // Major opcodes used by the front end.
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo; // Sits where rd would be.
        logic [6:0] opcode;
    } s_fmt_t;

    // One instruction word, three ways of reading it.
    typedef union packed {
        r_fmt_t r_view;
        i_fmt_t i_view;
        s_fmt_t s_view;
    } instr_word_u;

endpackage

`default_nettype wire

// ==== rv_fetch_pkg.sv ====
`default_nettype none

package rv_fetch_pkg;

    // ##################
    // Widths
    // ##################

    localparam int XLEN = 32; // Data and address width.

    // Word-address width of the instruction RAM, 64 words by default.
    localparam int IMEM_AW_DEFAULT = 6;

    // ##################
    // Reset state
    // ##################

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire
